//--- fpuPkg.sv
// FPU convert unit shared definitions
// widths, opcode and condition encodings, status codes and the
// FLDCX/FSTCX sub-op codes carried in the extension byte

package fpuPkg;

	// value widths
	localparam int dataWidth   = 64;
	localparam int singleWidth = 32;
	localparam int halfWidth   = 16;

	// low six bits of the command byte
	typedef enum logic [5:0] {
		opNop   = 6'h00,
		opFpu3  = 6'h19,	// arithmetic group, handled elsewhere
		opFldcx = 6'h1A,	// load-convert
		opFstcx = 6'h1B	// store-convert
	} fpuOpT;

	// command byte bits 7:6
	typedef enum logic [1:0] {
		ccAlways  = 2'd0,
		ccNever   = 2'd1,
		ccIfTrue  = 2'd2,	// run when SR.T set
		ccIfFalse = 2'd3	// run when SR.T clear
	} condT;

	// execute status back to the main unit
	typedef enum logic [1:0] {
		statReady = 2'd0,	// nothing done this cycle
		statOk    = 2'd1
	} outStatusT;

	// FLDCX sub-op, extension bits 2:0
	typedef enum logic [2:0] {
		ldSingle = 3'd0,
		ldMove   = 3'd1,
		ldHalf   = 3'd3
	} fldcxSubT;

	// FSTCX sub-op, extension bits 3:0
	typedef enum logic [3:0] {
		stSingle = 4'd0,
		stMove   = 4'd1,
		stHalf   = 4'd3,
		stPack   = 4'd8	// narrowed single over the low word
	} fstcxSubT;

	// extension bit picking the upper single word for ldSingle
	localparam int ixtHighWord = 3;

endpackage

//--- fpuLaneSelect.sv
`timescale 1ns/1ps
// FPU lane select and execute-stage latch
// takes the first lane holding a convert op, latches its command over
// exHold, and resolves condition code and flush in the execute cycle

module fpuLaneSelect (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [7:0]                    opCmdA,
	input  logic [7:0]                    opCmdB,
	input  logic [7:0]                    regIdIxtA,
	input  logic [7:0]                    regIdIxtB,
	input  logic [fpuPkg::dataWidth-1:0]  regValRsA,
	input  logic [fpuPkg::dataWidth-1:0]  regValRsB,
	input  logic [fpuPkg::dataWidth-1:0]  regInSr,
	input  logic                          braFlush,
	input  logic                          exHold,
	output fpuPkg::fpuOpT                 latOp,
	output logic [7:0]                    latIxt,
	output logic [fpuPkg::dataWidth-1:0]  latRs,
	output logic                          opEnable
);

	fpuPkg::fpuOpT opA;
	fpuPkg::fpuOpT opB;
	logic takeA;
	logic takeB;

	fpuPkg::fpuOpT nxtOp;
	fpuPkg::condT nxtCond;
	logic [7:0] nxtIxt;
	logic [fpuPkg::dataWidth-1:0] nxtRs;

	fpuPkg::condT latCond;
	logic latFlush;

	assign opA = fpuPkg::fpuOpT'(opCmdA[5:0]);
	assign opB = fpuPkg::fpuOpT'(opCmdB[5:0]);

	// only the convert ops belong here
	assign takeA = (opA == fpuPkg::opFldcx) || (opA == fpuPkg::opFstcx);
	assign takeB = !takeA && ((opB == fpuPkg::opFldcx) || (opB == fpuPkg::opFstcx));

	always_comb begin
		nxtOp   = fpuPkg::opNop;
		nxtCond = fpuPkg::ccNever;
		nxtIxt  = regIdIxtA;
		nxtRs   = regValRsA;
		if (takeA) begin
			nxtOp   = opA;
			nxtCond = fpuPkg::condT'(opCmdA[7:6]);
		end else if (takeB) begin
			nxtOp   = opB;
			nxtCond = fpuPkg::condT'(opCmdB[7:6]);
			nxtIxt  = regIdIxtB;
			nxtRs   = regValRsB;
		end
	end

	// control part of the latch
	always_ff @(posedge clock) begin
		if (reset) begin
			latOp    <= fpuPkg::opNop;
			latCond  <= fpuPkg::ccNever;
			latFlush <= 1'b0;
		end else if (!exHold) begin
			latOp    <= nxtOp;
			latCond  <= nxtCond;
			latFlush <= braFlush;	// flush seen in the capture cycle
		end
	end

	always_ff @(posedge clock) begin
		if (!exHold) begin
			latIxt <= nxtIxt;
			latRs  <= nxtRs;
		end
	end

	// condition against the live T bit
	always_comb begin
		if (latFlush || reset) begin
			opEnable = 1'b0;
		end else begin
			case (latCond)
				fpuPkg::ccAlways:  opEnable = 1'b1;
				fpuPkg::ccNever:   opEnable = 1'b0;
				fpuPkg::ccIfTrue:  opEnable = regInSr[0];
				fpuPkg::ccIfFalse: opEnable = !regInSr[0];
				default:           opEnable = 1'b0;
			endcase
		end
	end

	latOpKnown: assert property (@(posedge clock) reset |=> !$isunknown(latOp));

endmodule

//--- fpuConvWiden.sv
`timescale 1ns/1ps
// FPU widening converters
// single to double and half to double, subnormals flush to zero,
// infinity and NaN keep their mantissa bits

module fpuConvWiden (
	input  logic [fpuPkg::singleWidth-1:0] srcSingle,
	input  logic [fpuPkg::halfWidth-1:0]   srcHalf,
	output logic [fpuPkg::dataWidth-1:0]   singleToDouble,
	output logic [fpuPkg::dataWidth-1:0]   halfToDouble
);

	logic       sSign;
	logic [7:0] sExp;
	logic [22:0] sMant;

	logic       hSign;
	logic [4:0] hExp;
	logic [9:0] hMant;

	assign sSign = srcSingle[31];
	assign sExp  = srcSingle[30:23];
	assign sMant = srcSingle[22:0];

	assign hSign = srcHalf[15];
	assign hExp  = srcHalf[14:10];
	assign hMant = srcHalf[9:0];

	// single -> double
	always_comb begin
		if (sExp == 8'd0) begin
			singleToDouble = {sSign, 63'd0};	// zero or subnormal
		end else if (sExp == 8'hFF) begin
			singleToDouble = {sSign, 11'h7FF, sMant, 29'd0};
		end else begin
			// rebias 127 -> 1023
			singleToDouble = {sSign, {3'd0, sExp} + 11'd896, sMant, 29'd0};
		end
	end

	// half -> double
	always_comb begin
		if (hExp == 5'd0) begin
			halfToDouble = {hSign, 63'd0};
		end else if (hExp == 5'h1F) begin
			halfToDouble = {hSign, 11'h7FF, hMant, 42'd0};	// inf / NaN
		end else begin
			halfToDouble = {hSign, {6'd0, hExp} + 11'd1008, hMant, 42'd0};	// 15 -> 1023
		end
	end

endmodule

//--- fpuConvNarrow.sv
`timescale 1ns/1ps
// FPU narrowing converters
// double to single and double to half by truncation; small values
// go to signed zero, large ones to signed infinity

module fpuConvNarrow (
	input  logic [fpuPkg::dataWidth-1:0]   srcDouble,
	output logic [fpuPkg::singleWidth-1:0] doubleToSingle,
	output logic [fpuPkg::halfWidth-1:0]   doubleToHalf
);

	logic        dSign;
	logic [10:0] dExp;
	logic [51:0] dMant;
	logic        mantNz;

	logic [10:0] sExpFull;
	logic [10:0] hExpFull;

	assign dSign  = srcDouble[63];
	assign dExp   = srcDouble[62:52];
	assign dMant  = srcDouble[51:0];
	assign mantNz = |dMant;	// keeps a NaN a NaN after truncation

	// rebiased exponents, only the low bits survive in range
	assign sExpFull = dExp - 11'd896;
	assign hExpFull = dExp - 11'd1008;

	// double -> single
	always_comb begin
		if (dExp == 11'h7FF) begin
			doubleToSingle = {dSign, 8'hFF, dMant[51] | mantNz, dMant[50:29]};
		end else if (dExp <= 11'd896) begin
			doubleToSingle = {dSign, 31'd0};	// underflow
		end else if (dExp >= 11'd1151) begin
			doubleToSingle = {dSign, 8'hFF, 23'd0};	// overflow
		end else begin
			doubleToSingle = {dSign, sExpFull[7:0], dMant[51:29]};
		end
	end

	// double -> half
	always_comb begin
		if (dExp == 11'h7FF) begin
			doubleToHalf = {dSign, 5'h1F, dMant[51] | mantNz, dMant[50:42]};
		end else if (dExp <= 11'd1008) begin
			doubleToHalf = {dSign, 15'd0};
		end else if (dExp >= 11'd1039) begin
			doubleToHalf = {dSign, 5'h1F, 10'd0};
		end else begin
			doubleToHalf = {dSign, hExpFull[4:0], dMant[51:42]};
		end
	end

	// signed zero survives both paths
	always_comb begin
		if (srcDouble[62:0] == 63'd0) begin
			zeroKeepsSign: assert #0 (
				doubleToSingle == {srcDouble[63], 31'd0} &&
				doubleToHalf == {srcDouble[63], 15'd0});
		end
	end

endmodule

//--- fpuConvExec.sv
`timescale 1ns/1ps
// FPU convert execute stage
// decodes the latched FLDCX/FSTCX command, feeds the widening converter
// and picks the result word and status for the main unit

module fpuConvExec (
	input  fpuPkg::fpuOpT                  latOp,
	input  logic [7:0]                     latIxt,
	input  logic [fpuPkg::dataWidth-1:0]   latRs,
	input  logic                           opEnable,
	input  logic [fpuPkg::dataWidth-1:0]   singleToDouble,
	input  logic [fpuPkg::dataWidth-1:0]   halfToDouble,
	input  logic [fpuPkg::singleWidth-1:0] doubleToSingle,
	input  logic [fpuPkg::halfWidth-1:0]   doubleToHalf,
	output logic [fpuPkg::dataWidth-1:0]   regValGRn,
	output fpuPkg::outStatusT              regOutOK,
	output logic [fpuPkg::singleWidth-1:0] srcSingle,
	output logic [fpuPkg::halfWidth-1:0]   srcHalf
);

	localparam int singlePad = fpuPkg::dataWidth - fpuPkg::singleWidth;
	localparam int halfPad   = fpuPkg::dataWidth - fpuPkg::halfWidth;

	// upper or lower single word of Rs
	assign srcSingle = latIxt[fpuPkg::ixtHighWord] ?
		latRs[fpuPkg::dataWidth-1:fpuPkg::singleWidth] :
		latRs[fpuPkg::singleWidth-1:0];
	assign srcHalf = latRs[fpuPkg::halfWidth-1:0];

	always_comb begin
		regValGRn = '0;
		regOutOK  = fpuPkg::statReady;
		if (opEnable) begin
			case (latOp)
				fpuPkg::opFldcx: begin
					regOutOK = fpuPkg::statOk;
					case (latIxt[2:0])
						fpuPkg::ldSingle: regValGRn = singleToDouble;
						fpuPkg::ldHalf:   regValGRn = halfToDouble;
						fpuPkg::ldMove:   regValGRn = latRs;
						default:          regValGRn = '0;
					endcase
				end
				fpuPkg::opFstcx: begin
					regOutOK = fpuPkg::statOk;
					case (latIxt[3:0])
						fpuPkg::stSingle: regValGRn = {{singlePad{1'b0}}, doubleToSingle};
						fpuPkg::stHalf:   regValGRn = {{halfPad{1'b0}}, doubleToHalf};
						fpuPkg::stMove:   regValGRn = latRs;
						fpuPkg::stPack: begin
							regValGRn = {doubleToSingle, latRs[fpuPkg::singleWidth-1:0]};
						end
						default:          regValGRn = '0;
					endcase
				end
				default: begin
					regValGRn = '0;	// nop or arithmetic group, not for this unit
				end
			endcase
		end
	end

	// a done status needs a live command
	always_comb begin
		if (regOutOK == fpuPkg::statOk) begin
			okNeedsEnable: assert #0 (opEnable &&
				(latOp == fpuPkg::opFldcx || latOp == fpuPkg::opFstcx));
		end
	end

endmodule

//--- fpuExOpW.sv
`timescale 1ns/1ps
// FPU wide execute unit, convert and move slave
// lane select and latch, widening and narrowing converters and the
// result select, one cycle from command to result

module fpuExOpW (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [7:0]                   opCmdA,
	input  logic [7:0]                   opCmdB,
	input  logic [7:0]                   regIdIxtA,
	input  logic [7:0]                   regIdIxtB,
	input  logic [fpuPkg::dataWidth-1:0] regValRsA,
	input  logic [fpuPkg::dataWidth-1:0] regValRsB,
	input  logic [fpuPkg::dataWidth-1:0] regInSr,
	input  logic                         braFlush,
	input  logic                         exHold,
	output logic [fpuPkg::dataWidth-1:0] regValGRn,
	output fpuPkg::outStatusT            regOutOK
);

	fpuPkg::fpuOpT latOp;
	logic [7:0] latIxt;
	logic [fpuPkg::dataWidth-1:0] latRs;
	logic opEnable;

	logic [fpuPkg::singleWidth-1:0] srcSingle;
	logic [fpuPkg::halfWidth-1:0] srcHalf;
	logic [fpuPkg::dataWidth-1:0] singleToDouble;
	logic [fpuPkg::dataWidth-1:0] halfToDouble;
	logic [fpuPkg::singleWidth-1:0] doubleToSingle;
	logic [fpuPkg::halfWidth-1:0] doubleToHalf;

	fpuLaneSelect laneSel (
		.clock(clock), .reset(reset),
		.opCmdA(opCmdA), .opCmdB(opCmdB),
		.regIdIxtA(regIdIxtA), .regIdIxtB(regIdIxtB),
		.regValRsA(regValRsA), .regValRsB(regValRsB),
		.regInSr(regInSr), .braFlush(braFlush), .exHold(exHold),
		.latOp(latOp), .latIxt(latIxt), .latRs(latRs), .opEnable(opEnable)
	);

	fpuConvWiden widen (
		.srcSingle(srcSingle), .srcHalf(srcHalf),
		.singleToDouble(singleToDouble), .halfToDouble(halfToDouble)
	);

	fpuConvNarrow narrow (
		.srcDouble(latRs),	// store side always narrows Rs
		.doubleToSingle(doubleToSingle), .doubleToHalf(doubleToHalf)
	);

	fpuConvExec exec (
		.latOp(latOp), .latIxt(latIxt), .latRs(latRs), .opEnable(opEnable),
		.singleToDouble(singleToDouble), .halfToDouble(halfToDouble),
		.doubleToSingle(doubleToSingle), .doubleToHalf(doubleToHalf),
		.regValGRn(regValGRn), .regOutOK(regOutOK),
		.srcSingle(srcSingle), .srcHalf(srcHalf)
	);

endmodule

//--- fpuExOpW_tb.sv
`timescale 1ns/1ps
// testbench for the FPU convert and move slave unit
// replays the vector file one command per cycle and checks status
// and result one cycle after each command is presented

module fpuExOpW_tb;

	localparam int fieldsPerVec = 11;	// hex tokens on one vector line
	localparam int maxVectors   = 256;

	logic clock;
	logic reset;
	logic [7:0] opCmdA;
	logic [7:0] opCmdB;
	logic [7:0] regIdIxtA;
	logic [7:0] regIdIxtB;
	logic [fpuPkg::dataWidth-1:0] regValRsA;
	logic [fpuPkg::dataWidth-1:0] regValRsB;
	logic [fpuPkg::dataWidth-1:0] regInSr;
	logic braFlush;
	logic exHold;
	logic [fpuPkg::dataWidth-1:0] regValGRn;
	fpuPkg::outStatusT regOutOK;

	logic [63:0] vecMem [0:fieldsPerVec*maxVectors-1];
	int numVectors;
	int cycleCount;
	int cycleLimit;

	fpuExOpW dut (
		.clock(clock), .reset(reset),
		.opCmdA(opCmdA), .opCmdB(opCmdB),
		.regIdIxtA(regIdIxtA), .regIdIxtB(regIdIxtB),
		.regValRsA(regValRsA), .regValRsB(regValRsB),
		.regInSr(regInSr), .braFlush(braFlush), .exHold(exHold),
		.regValGRn(regValGRn), .regOutOK(regOutOK)
	);

	// 20 ns period
	always begin
		#10 clock = ~clock;
	end

	// ends the run after the first error
	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic checkStatus(input fpuPkg::outStatusT got, input fpuPkg::outStatusT expected,
		input string label);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: %s status %0d, expected %0d", $time, label, got, expected);
			abortRun();
		end
	endtask

	task automatic checkResult(input logic [fpuPkg::dataWidth-1:0] got,
		input logic [fpuPkg::dataWidth-1:0] expected, input string label);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: %s result %h, expected %h", $time, label, got, expected);
			abortRun();
		end
	endtask

	// put one vector line on the DUT inputs
	task automatic applyVector(input int idx);
		int base;
		base = idx * fieldsPerVec;
		opCmdA    = vecMem[base][7:0];
		regIdIxtA = vecMem[base+1][7:0];
		regValRsA = vecMem[base+2];
		opCmdB    = vecMem[base+3][7:0];
		regIdIxtB = vecMem[base+4][7:0];
		regValRsB = vecMem[base+5];
		regInSr   = {63'd0, vecMem[base+6][0]};	// only T matters
		braFlush  = vecMem[base+7][0];
		exHold    = vecMem[base+8][0];
	endtask

	// watchdog, limit set once the vectors are counted
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
			abortRun();
		end
	end

	initial begin
		int i;
		int base;
		string label;

		clock      = 1'b0;
		reset      = 1'b1;
		opCmdA     = 8'h00;
		opCmdB     = 8'h00;
		regIdIxtA  = 8'h00;
		regIdIxtB  = 8'h00;
		regValRsA  = '0;
		regValRsB  = '0;
		regInSr    = '0;
		braFlush   = 1'b0;
		exHold     = 1'b0;
		cycleCount = 0;
		cycleLimit = 20;

		$readmemh("fpuExOpW_vectors.txt", vecMem);
		numVectors = 0;
		while (numVectors < maxVectors &&
			!$isunknown(vecMem[numVectors*fieldsPerVec])) begin
			numVectors++;
		end
		if (numVectors == 0) begin
			$display("no vectors could be read from fpuExOpW_vectors.txt");
			abortRun();
		end
		cycleLimit = 2 * numVectors + 20;

		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// latch comes out of reset holding a nop
		@(posedge clock);
		#2;
		checkStatus(regOutOK, fpuPkg::statReady, "after reset");
		checkResult(regValGRn, '0, "after reset");

		for (i = 0; i < numVectors; i++) begin
			@(negedge clock);
			applyVector(i);
			@(posedge clock);
			#2;	// outputs settle well before the next falling edge
			base  = i * fieldsPerVec;
			label = $sformatf("vector %0d", i);
			checkStatus(regOutOK, fpuPkg::outStatusT'(vecMem[base+9][1:0]), label);
			checkResult(regValGRn, vecMem[base+10], label);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- fpuExOpW_vectors.txt
// opCmdA regIdIxtA regValRsA opCmdB regIdIxtB regValRsB T braFlush exHold
// then expected regOutOK and regValGRn, all hex, one line per cycle
1A 00 0000000040490FDB 00 00 0000000000000000 0 0 0 1 400921FB60000000
1A 08 C00000003F800000 00 00 0000000000000000 0 0 0 1 C000000000000000
1A 00 C00000003F800000 00 00 0000000000000000 0 0 0 1 3FF0000000000000
1A 03 123456780000C500 00 00 0000000000000000 0 0 0 1 C014000000000000
1A 01 0123456789ABCDEF 00 00 0000000000000000 0 0 0 1 0123456789ABCDEF
1A 00 000000007F800000 00 00 0000000000000000 0 0 0 1 7FF0000000000000
1A 00 000000007FC00001 00 00 0000000000000000 0 0 0 1 7FF8000020000000
1A 08 8000000000000000 00 00 0000000000000000 0 0 0 1 8000000000000000
1A 00 0000000000000001 00 00 0000000000000000 0 0 0 1 0000000000000000
1A 03 000000000000FC00 00 00 0000000000000000 0 0 0 1 FFF0000000000000
1A 03 0000000000007E00 00 00 0000000000000000 0 0 0 1 7FF8000000000000
1A 03 0000000000000001 00 00 0000000000000000 0 0 0 1 0000000000000000
// store-convert
1B 00 400921FB54442D18 00 00 0000000000000000 0 0 0 1 0000000040490FDA
1B 00 B800000000000000 00 00 0000000000000000 0 0 0 1 0000000080000000
1B 00 47F0000000000000 00 00 0000000000000000 0 0 0 1 000000007F800000
1B 00 47EFFFFFFFFFFFFF 00 00 0000000000000000 0 0 0 1 000000007F7FFFFF
1B 00 7FF0000000000001 00 00 0000000000000000 0 0 0 1 000000007FC00000
1B 00 FFF0000000000000 00 00 0000000000000000 0 0 0 1 00000000FF800000
1B 03 C014000000000000 00 00 0000000000000000 0 0 0 1 000000000000C500
1B 03 3FF5555555555555 00 00 0000000000000000 0 0 0 1 0000000000003D55
1B 03 40F0000000000000 00 00 0000000000000000 0 0 0 1 0000000000007C00
1B 03 40E0000000000000 00 00 0000000000000000 0 0 0 1 0000000000007800
1B 03 BF00000000000000 00 00 0000000000000000 0 0 0 1 0000000000008000
1B 03 7FF8000000000000 00 00 0000000000000000 0 0 0 1 0000000000007E00
1B 01 FEDCBA9876543210 00 00 0000000000000000 0 0 0 1 FEDCBA9876543210
1B 08 3FF0000012345678 00 00 0000000000000000 0 0 0 1 3F80000012345678
// lane choice
1A 01 1111111111111111 1B 01 2222222222222222 0 0 0 1 1111111111111111
19 01 7777777777777777 1B 01 3333333333333333 0 0 0 1 3333333333333333
00 00 0000000000000000 1A 01 4444444444444444 0 0 0 1 4444444444444444
19 01 7777777777777777 00 01 8888888888888888 0 0 0 0 0000000000000000
5A 01 9999999999999999 1B 01 2222222222222222 0 0 0 0 0000000000000000
// predication and flush
5A 01 AAAAAAAAAAAAAAAA 00 00 0000000000000000 0 0 0 0 0000000000000000
9A 01 AAAAAAAAAAAAAAAA 00 00 0000000000000000 1 0 0 1 AAAAAAAAAAAAAAAA
9B 01 BBBBBBBBBBBBBBBB 00 00 0000000000000000 0 0 0 0 0000000000000000
DA 01 CCCCCCCCCCCCCCCC 00 00 0000000000000000 0 0 0 1 CCCCCCCCCCCCCCCC
DB 01 DDDDDDDDDDDDDDDD 00 00 0000000000000000 1 0 0 0 0000000000000000
1A 01 EEEEEEEEEEEEEEEE 00 00 0000000000000000 0 1 0 0 0000000000000000
1A 01 0F0F0F0F0F0F0F0F 00 00 0000000000000000 0 0 0 1 0F0F0F0F0F0F0F0F
// stall
1A 01 5555555555555555 00 00 0000000000000000 0 0 0 1 5555555555555555
1B 03 6666666666666666 00 00 0000000000000000 0 1 1 1 5555555555555555
00 00 0000000000000000 00 00 0000000000000000 1 0 1 1 5555555555555555
00 00 0000000000000000 00 00 0000000000000000 0 0 0 0 0000000000000000
1A 01 123456789ABCDEF0 00 00 0000000000000000 0 0 1 0 0000000000000000
1B 00 47F0000000000000 00 00 0000000000000000 0 0 0 1 000000007F800000

//--- compile.f
fpuPkg.sv
fpuLaneSelect.sv
fpuConvWiden.sv
fpuConvNarrow.sv
fpuConvExec.sv
fpuExOpW.sv
fpuExOpW_tb.sv
